//--- design/avl_bridge_pkg.sv
`default_nettype none

package avl_bridge_pkg;

  localparam int ADDR_W = 32;               // byte address width
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;
  localparam int BE_W   = DATA_W / BYTE_W;  // byte lanes per word
  localparam int OFF_W  = $clog2(BE_W);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [BE_W-1:0]   byte_en_t;
  typedef logic [OFF_W-1:0]  byte_off_t;

  // sequencer orders a data access ahead of the instruction fetch
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    FETCH_INSTR = 3'd1,
    FETCH_DATA  = 3'd2,
    INSTR_SET   = 3'd3,
    HALTED      = 3'd4
  } seq_state_t;

  localparam byte_en_t BE_FULL = 4'b1111;   // whole word, offset 0

endpackage

`default_nettype wire

//--- design/bus_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module bus_sequencer (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       active,
  input  logic                       data_read,
  input  logic                       data_write,
  input  logic                       av_waitrequest,
  output avl_bridge_pkg::seq_state_t state,
  output logic                       clk_enable,
  output logic                       data_done,
  output logic                       instr_done
);

  import avl_bridge_pkg::*;

  seq_state_t state_next;
  logic       data_req;   // exactly one data strobe raised
  logic       bus_ready;  // slave takes the command this edge

  assign data_req  = data_read ^ data_write;
  assign bus_ready = !av_waitrequest;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= state_next;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (data_req)
        begin
          state_next = FETCH_DATA;    // data goes first
        end
        else if (active)
        begin
          state_next = FETCH_INSTR;
        end
      end
      FETCH_DATA:
      begin
        if (bus_ready)
        begin
          if (active)
          begin
            state_next = INSTR_SET;   // running cpu also needs its next instruction
          end
          else
          begin
            state_next = HALTED;
          end
        end
      end
      INSTR_SET:
      begin
        state_next = FETCH_INSTR;
      end
      FETCH_INSTR:
      begin
        if (bus_ready)
        begin
          state_next = HALTED;
        end
      end
      HALTED:
      begin
        state_next = IDLE;
      end
      default:
      begin
        state_next = IDLE;
      end
    endcase
  end

  // strobes land on the completing edge only
  assign data_done  = (state == FETCH_DATA) && bus_ready;
  assign instr_done = (state == FETCH_INSTR) && bus_ready;

  // Processor runs while nothing is requested, and gets exactly one
  // cycle in HALTED once a sequence has finished.
  always_comb
  begin
    case (state)
      IDLE:
      begin
        clk_enable = !(data_req || active);
      end
      HALTED:
      begin
        clk_enable = 1'b1;            // single release cycle
      end
      default:
      begin
        clk_enable = 1'b0;            // access in flight
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/request_mux.sv
`timescale 1ns/10ps
`default_nettype none

module request_mux (
  input  avl_bridge_pkg::seq_state_t state,
  input  avl_bridge_pkg::addr_t      instr_address,
  input  avl_bridge_pkg::addr_t      data_address,
  input  logic                       data_read,
  input  logic                       data_write,
  input  avl_bridge_pkg::word_t      lane_writedata,
  output avl_bridge_pkg::addr_t      av_address,
  output logic                       av_read,
  output logic                       av_write,
  output avl_bridge_pkg::word_t      av_writedata
);

  import avl_bridge_pkg::*;

  addr_t word_address;

  assign word_address = {data_address[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};  // drop byte offset

  always_comb
  begin
    av_address   = '0;
    av_read      = 1'b0;
    av_write     = 1'b0;
    av_writedata = '0;
    case (state)
      FETCH_DATA:
      begin
        av_address   = word_address;
        av_read      = data_read;
        av_write     = data_write;
        av_writedata = lane_writedata;
      end
      INSTR_SET, FETCH_INSTR:
      begin
        av_address = instr_address;   // instruction reads are always whole words
        av_read    = 1'b1;
      end
      default:
      begin
        av_read  = 1'b0;              // bus idle
        av_write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/write_lane_aligner.sv
`timescale 1ns/10ps
`default_nettype none

module write_lane_aligner (
  input  avl_bridge_pkg::addr_t    data_address,
  input  avl_bridge_pkg::word_t    data_writedata,
  output avl_bridge_pkg::byte_en_t av_byteenable,
  output avl_bridge_pkg::word_t    lane_writedata
);

  import avl_bridge_pkg::*;

  byte_off_t offset;
  word_t     shift_bits;  // lane shift in bits

  assign offset     = data_address[OFF_W-1:0];
  assign shift_bits = word_t'(offset) * BYTE_W;

  // offset 0..3 gives 1111, 1110, 1100, 1000
  assign av_byteenable = BE_FULL << offset;

  // low bytes of the cpu word move up into the enabled lanes
  assign lane_writedata = data_writedata << shift_bits;

endmodule

`default_nettype wire

//--- design/read_capture.sv
`timescale 1ns/10ps
`default_nettype none

module read_capture (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  data_done,
  input  logic                  instr_done,
  input  logic                  data_read,
  input  avl_bridge_pkg::addr_t data_address,
  input  avl_bridge_pkg::word_t av_readdata,
  output avl_bridge_pkg::word_t instr_readdata,
  output avl_bridge_pkg::word_t data_readdata
);

  import avl_bridge_pkg::*;

  byte_off_t offset;
  word_t     shift_bits;
  word_t     data_shifted;  // addressed byte moved down to bit 0

  assign offset       = data_address[OFF_W-1:0];
  assign shift_bits   = word_t'(offset) * BYTE_W;
  assign data_shifted = av_readdata >> shift_bits;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      instr_readdata <= '0;
    end
    else if (instr_done)
    begin
      instr_readdata <= av_readdata;
    end
  end

  // a completed write leaves the last read value in place
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      data_readdata <= '0;
    end
    else if (data_done && data_read)
    begin
      data_readdata <= data_shifted;
    end
  end

endmodule

`default_nettype wire

//--- design/harvard_avalon_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module harvard_avalon_bridge (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     active,
  output logic                     clk_enable,
  input  avl_bridge_pkg::addr_t    instr_address,
  output avl_bridge_pkg::word_t    instr_readdata,
  input  avl_bridge_pkg::addr_t    data_address,
  input  logic                     data_read,
  input  logic                     data_write,
  input  avl_bridge_pkg::word_t    data_writedata,
  output avl_bridge_pkg::word_t    data_readdata,
  output avl_bridge_pkg::addr_t    av_address,
  output logic                     av_read,
  output logic                     av_write,
  output avl_bridge_pkg::word_t    av_writedata,
  output avl_bridge_pkg::byte_en_t av_byteenable,
  input  avl_bridge_pkg::word_t    av_readdata,
  input  logic                     av_waitrequest
);

  import avl_bridge_pkg::*;

  seq_state_t state;
  logic       data_done;
  logic       instr_done;
  word_t      lane_writedata;  // write data already in its byte lanes

  bus_sequencer u_bus_sequencer (
    .clk            (clk),
    .arst_n         (arst_n),
    .active         (active),
    .data_read      (data_read),
    .data_write     (data_write),
    .av_waitrequest (av_waitrequest),
    .state          (state),
    .clk_enable     (clk_enable),
    .data_done      (data_done),
    .instr_done     (instr_done)
  );

  request_mux u_request_mux (
    .state          (state),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_read      (data_read),
    .data_write     (data_write),
    .lane_writedata (lane_writedata),
    .av_address     (av_address),
    .av_read        (av_read),
    .av_write       (av_write),
    .av_writedata   (av_writedata)
  );

  write_lane_aligner u_write_lane_aligner (
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .av_byteenable  (av_byteenable),
    .lane_writedata (lane_writedata)
  );

  read_capture u_read_capture (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_done      (data_done),
    .instr_done     (instr_done),
    .data_read      (data_read),
    .data_address   (data_address),
    .av_readdata    (av_readdata),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata)
  );

endmodule

`default_nettype wire

//--- tb/avalon_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module avalon_mem_model (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     stall_en,
  input  avl_bridge_pkg::addr_t    av_address,
  input  logic                     av_read,
  input  logic                     av_write,
  input  avl_bridge_pkg::word_t    av_writedata,
  input  avl_bridge_pkg::byte_en_t av_byteenable,
  output avl_bridge_pkg::word_t    av_readdata,
  output logic                     av_waitrequest
);

  import avl_bridge_pkg::*;

  word_t      mem [0:255];
  logic [7:0] widx;       // word index, byte offset ignored
  word_t      lane_mask;  // byteenable widened to bits
  integer     seed;
  integer     rnd;

  assign widx        = av_address[9:2];
  assign av_readdata = mem[widx];
  assign lane_mask   = {{8{av_byteenable[3]}}, {8{av_byteenable[2]}},
                        {8{av_byteenable[1]}}, {8{av_byteenable[0]}}};

  initial
  begin
    seed = 32'h4ae4_25d5;
    for (int i = 0; i < 256; i++)
    begin
      mem[i] = (i + 1) * 32'h9e37_79b9;  // every word distinct
    end
  end

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      av_waitrequest <= 1'b0;
    end
    else
    begin
      rnd = $random(seed);
      av_waitrequest <= stall_en && rnd[0];  // new stall decision each cycle
    end
  end

  always @(posedge clk)
  begin
    if (av_write && !av_waitrequest)
    begin
      mem[widx] <= (mem[widx] & ~lane_mask) | (av_writedata & lane_mask);
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bridge;

  import avl_bridge_pkg::*;

  localparam int NUM_TRANS   = 48;
  localparam int CYCLE_LIMIT = NUM_TRANS * 40;

  logic     clk;
  logic     arst_n;
  logic     active;
  logic     clk_enable;
  logic     data_read;
  logic     data_write;
  logic     av_read;
  logic     av_write;
  logic     av_waitrequest;
  logic     stall_en;        // random waitrequest on or off
  addr_t    instr_address;
  addr_t    data_address;
  addr_t    av_address;
  word_t    instr_readdata;
  word_t    data_writedata;
  word_t    data_readdata;
  word_t    av_writedata;
  word_t    av_readdata;
  byte_en_t av_byteenable;

  word_t    shadow [0:255];  // expected memory contents
  word_t    exp_instr;
  word_t    exp_data;
  integer   seed;
  integer   rnd;
  int       word_errors;
  int       bit_errors;
  int       addr_errors;
  int       count_errors;
  int       cycle_count;
  int       write_count;     // completed Avalon writes
  int       cmd_cycles;      // cycles with any Avalon command raised

  harvard_avalon_bridge UUT (.*);
  avalon_mem_model u_mem (.*);

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (av_write && !av_waitrequest)
    begin
      write_count <= write_count + 1;
    end
    if (av_read || av_write)
    begin
      cmd_cycles <= cmd_cycles + 1;
    end
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: a bus sequence did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  // cpu bytes land in the lanes from the offset upward
  function automatic word_t merge_write(input word_t old_word, input word_t wdata,
                                        input int off);
    word_t res;
    res = old_word;
    for (int b = off; b < 4; b++)
    begin
      res[8*b +: 8] = wdata[8*(b-off) +: 8];
    end
    return res;
  endfunction

  function automatic word_t shift_read(input word_t stored, input int off);
    word_t res;
    res = '0;
    for (int b = off; b < 4; b++)
    begin
      res[8*(b-off) +: 8] = stored[8*b +: 8];  // upper lanes fill with zero
    end
    return res;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected)
    begin
      word_errors++;
      $display("FAILED %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
      bit_errors++;
      $display("FAILED %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t expected);
    if (got !== expected)
    begin
      addr_errors++;
      $display("FAILED %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic check_count(input string name, input int got, input int expected);
    if (got != expected)
    begin
      count_errors++;
      $display("FAILED %s got %h expected %h", name, got, expected);
    end
  endtask

  // one processor step, started on the edge where the sequencer is back in IDLE
  task automatic run_access(input logic act, input logic rd, input logic wr,
                            input addr_t daddr, input word_t wdata, input addr_t iaddr);
    logic data_req;
    logic data_phase;  // data access still pending
    logic in_set;      // INSTR_SET cycle, never waits
    int   off;
    int   low_cycles;
    int   exp_low;
    int   waits;
    int   writes_before;
    int   cmds_before;
    data_req      = rd ^ wr;
    data_phase    = data_req;
    in_set        = 1'b0;
    waits         = 0;
    off           = int'(daddr[1:0]);
    writes_before = write_count;
    cmds_before   = cmd_cycles;
    if (data_req && rd)
    begin
      exp_data = shift_read(shadow[daddr[9:2]], off);
    end
    if (data_req && wr)
    begin
      shadow[daddr[9:2]] = merge_write(shadow[daddr[9:2]], wdata, off);
    end
    if (act)
    begin
      exp_instr = shadow[iaddr[9:2]];  // fetched after the data access
    end
    exp_low = data_req ? (act ? 4 : 2) : (act ? 2 : 0);
    @(posedge clk);
    active         <= act;
    data_read      <= rd;
    data_write     <= wr;
    data_address   <= daddr;
    data_writedata <= wdata;
    instr_address  <= iaddr;
    @(negedge clk);
    check_bit("clk_enable", clk_enable, !(data_req || act));
    low_cycles = 0;
    while (!clk_enable)
    begin
      low_cycles++;
      if (av_read || av_write)
      begin
        check_addr("av_address", av_address, data_phase ? (daddr & 32'hffff_fffc) : iaddr);
        if (av_waitrequest && !in_set)
        begin
          waits++;
        end
        in_set     = data_phase && act && !av_waitrequest;
        data_phase = data_phase && av_waitrequest;  // completes at the next edge
      end
      @(negedge clk);
    end
    check_count("clk_enable low cycles", low_cycles, exp_low + waits);
    if (!data_req && !act)
    begin
      repeat (3)
      begin
        @(negedge clk);
        check_bit("clk_enable", clk_enable, 1'b1);
      end
      check_count("avalon command cycles", cmd_cycles - cmds_before, 0);
    end
    check_count("avalon writes", write_count - writes_before, (data_req && wr) ? 1 : 0);
    check_word("instr_readdata", instr_readdata, exp_instr);
    check_word("data_readdata", data_readdata, exp_data);
  endtask

  initial
  begin
    seed           = 32'h4ae4_25d5;
    clk            = 1'b0;
    arst_n         = 1'b0;
    active         = 1'b0;
    data_read      = 1'b0;
    data_write     = 1'b0;
    data_address   = '0;
    data_writedata = '0;
    instr_address  = '0;
    stall_en       = 1'b0;
    exp_instr      = '0;
    exp_data       = '0;
    word_errors    = 0;
    bit_errors     = 0;
    addr_errors    = 0;
    count_errors   = 0;
    cycle_count    = 0;
    write_count    = 0;
    cmd_cycles     = 0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_bit("clk_enable", clk_enable, 1'b1);
    check_bit("av_read", av_read, 1'b0);
    check_bit("av_write", av_write, 1'b0);
    check_word("instr_readdata", instr_readdata, '0);
    check_word("data_readdata", data_readdata, '0);
    for (int i = 0; i < 256; i++)
    begin
      shadow[i] = u_mem.mem[i];
    end
    run_access(1'b1, 1'b0, 1'b0, '0, '0, 32'h0000_0040);
    run_access(1'b0, 1'b0, 1'b1, 32'h0000_0100, 32'hdead_beef, '0);
    run_access(1'b0, 1'b1, 1'b0, 32'h0000_0100, '0, '0);
    for (int off = 1; off < 4; off++)
    begin
      run_access(1'b0, 1'b0, 1'b1, 32'h200 + off * 5, 32'h1122_3344, '0);
      run_access(1'b0, 1'b1, 1'b0, 32'h200 + off * 4, '0, '0);  // aligned read-back
      run_access(1'b0, 1'b1, 1'b0, 32'h200 + off * 5, '0, '0);
    end
    run_access(1'b1, 1'b0, 1'b1, 32'h0000_0302, 32'h0000_a5c3, 32'h0000_0300);
    run_access(1'b0, 1'b0, 1'b1, 32'h0000_0310, 32'h7777_0001, 32'h0000_0080);
    run_access(1'b0, 1'b1, 1'b1, 32'h0000_0100, 32'h0bad_0bad, '0);
    @(posedge clk);
    stall_en <= 1'b1;
    run_access(1'b0, 1'b1, 1'b0, 32'h0000_0100, '0, '0);
    for (int n = 0; n < 32; n++)
    begin
      rnd = $random(seed);
      run_access(rnd[0], rnd[1], rnd[2], {22'd0, rnd[12:3]}, $random(seed),
                 {22'd0, rnd[20:13], 2'b00});
    end
    @(posedge clk);
    active     <= 1'b0;
    data_read  <= 1'b0;
    data_write <= 1'b0;
    @(negedge clk);
    $display("errors: word %0d, bit %0d, addr %0d, count %0d",
             word_errors, bit_errors, addr_errors, count_errors);
    if (word_errors + bit_errors + addr_errors + count_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
design/avl_bridge_pkg.sv
design/bus_sequencer.sv
design/request_mux.sv
design/write_lane_aligner.sv
design/read_capture.sv
design/harvard_avalon_bridge.sv
tb/avalon_mem_model.sv
tb/tb_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
rm -f sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module tb_bridge -f flist.f \
  -o sim_bridge > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_bridge > sim.log 2>&1
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
